// File: hdl/core_pkg.sv
package core_pkg;

    // datapath width of the integer units
    localparam int LEN_WORD = 32;

    // 64 physical registers in the rename pool
    localparam int LEN_PREG_ADDR = 6;

    // one operand or result word
    typedef logic [LEN_WORD-1:0] word_t;

    // physical destination tag carried alongside a result
    typedef logic [LEN_PREG_ADDR-1:0] preg_addr_t;

endpackage

// File: hdl/div_pkg.sv
package div_pkg;

    // quotient bits resolved per digit step
    localparam int RADIX_BITS = 4;

    // eight steps cover the 32-bit dividend
    localparam int DIGIT_STEPS = core_pkg::LEN_WORD / RADIX_BITS;

    // nonzero divisor multiples 1 to 15
    localparam int MULTIPLES = 2**RADIX_BITS - 1;

    // bit s set means a pipeline register follows digit step s
    localparam logic [DIGIT_STEPS-1:0] STEP_REG_MASK = 8'b0010_0100;

    // divisor times digit, four bits wider than a word
    typedef logic [core_pkg::LEN_WORD+RADIX_BITS-1:0] multiple_t;

    // bit 1 picks the remainder, bit 0 marks unsigned
    typedef enum logic [1:0] {
        DIV  = 2'b00,
        DIVU = 2'b01,
        REM  = 2'b10,
        REMU = 2'b11
    } div_op_t;

    typedef struct packed {
        div_op_t             op;
        core_pkg::word_t     dividend;
        core_pkg::word_t     divisor;
        core_pkg::preg_addr_t tag;
    } div_req_t;

    // facts needed after the unsigned core, travels with the data
    typedef struct packed {
        core_pkg::preg_addr_t tag;
        logic                want_rem;
        logic                neg_quot;
        logic                neg_rem;
        logic                div_by_zero;
        core_pkg::word_t     dividend;
    } div_meta_t;

    typedef struct packed {
        core_pkg::word_t      value;
        core_pkg::preg_addr_t tag;
    } div_result_t;

endpackage

// File: hdl/div_digit_step.sv
`timescale 1ns/10ps

module div_digit_step (
    input  logic [2*core_pkg::LEN_WORD-1:0] rem_in,
    input  core_pkg::word_t                 quot_in,
    input  div_pkg::multiple_t              multiples [div_pkg::MULTIPLES],
    output logic [2*core_pkg::LEN_WORD-1:0] rem_out,
    output core_pkg::word_t                 quot_out
);
    import core_pkg::*;
    import div_pkg::*;

    // window of the partial remainder compared against the multiples
    multiple_t top;
    // window after removing the chosen multiple
    multiple_t diff;
    logic [RADIX_BITS-1:0] digit;

    assign top = rem_in[2*LEN_WORD-1 -: $bits(multiple_t)];

    // multiples ascend, so the last one that fits is the largest
    always_comb begin
        digit = '0;
        diff  = top;
        for (int i = 0; i < MULTIPLES; i++) begin
            if (top >= multiples[i]) begin
                digit = RADIX_BITS'(i + 1);
                diff  = top - multiples[i];
            end
        end
    end

    // what is left is below the divisor, so the low word of diff holds it
    assign rem_out = {
        diff[LEN_WORD-1:0],
        rem_in[LEN_WORD-RADIX_BITS-1:0],
        {RADIX_BITS{1'b0}}
    };

    // new digit enters at the bottom of the quotient
    assign quot_out = {quot_in[LEN_WORD-RADIX_BITS-1:0], digit};

endmodule

// File: hdl/divu_pipeline.sv
`timescale 1ns/10ps

module divu_pipeline (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                in_valid,
    input  core_pkg::word_t     dividend,
    input  core_pkg::word_t     divisor,
    input  div_pkg::div_meta_t  meta_in,
    output logic                out_valid,
    output core_pkg::word_t     quotient,
    output core_pkg::word_t     remainder,
    output div_pkg::div_meta_t  meta_out
);
    import core_pkg::*;
    import div_pkg::*;

    // values at the boundary in front of each digit step, index 8 is the end
    logic                    valid_b [DIGIT_STEPS+1];
    logic [2*LEN_WORD-1:0]   rem_b   [DIGIT_STEPS+1];
    word_t                   quot_b  [DIGIT_STEPS+1];
    div_meta_t               meta_b  [DIGIT_STEPS+1];
    // multiples are only consumed by the steps, so no end entry
    multiple_t               mult_b  [DIGIT_STEPS][MULTIPLES];

    // raw outputs of each digit step
    logic [2*LEN_WORD-1:0]   rem_nx  [DIGIT_STEPS];
    word_t                   quot_nx [DIGIT_STEPS];

    // entry
    assign valid_b[0] = in_valid;
    assign rem_b[0]   = {{LEN_WORD{1'b0}}, dividend};
    assign quot_b[0]  = '0;
    assign meta_b[0]  = meta_in;

    // divisor multiples built once and carried along
    for (genvar i = 0; i < MULTIPLES; i++) begin : g_mult
        assign mult_b[0][i] = multiple_t'(divisor) * multiple_t'(i + 1);
    end

    for (genvar s = 0; s < DIGIT_STEPS; s++) begin : g_step
        div_digit_step u_step (
            .rem_in    (rem_b[s]),
            .quot_in   (quot_b[s]),
            .multiples (mult_b[s]),
            .rem_out   (rem_nx[s]),
            .quot_out  (quot_nx[s])
        );

        if (STEP_REG_MASK[s]) begin : g_reg
            logic                  valid_q;
            logic [2*LEN_WORD-1:0] rem_q;
            word_t                 quot_q;
            div_meta_t             meta_q;

            always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                    valid_q <= 1'b0;
                end else begin
                    valid_q <= valid_b[s];
                end
            end

            always_ff @(posedge clk) begin
                rem_q  <= rem_nx[s];
                quot_q <= quot_nx[s];
                meta_q <= meta_b[s];
            end

            assign valid_b[s+1] = valid_q;
            assign rem_b[s+1]   = rem_q;
            assign quot_b[s+1]  = quot_q;
            assign meta_b[s+1]  = meta_q;

            if (s < DIGIT_STEPS - 1) begin : g_mult_reg
                multiple_t mult_q [MULTIPLES];

                always_ff @(posedge clk) begin
                    mult_q <= mult_b[s];
                end

                assign mult_b[s+1] = mult_q;
            end
        end else begin : g_pass
            assign valid_b[s+1] = valid_b[s];
            assign rem_b[s+1]   = rem_nx[s];
            assign quot_b[s+1]  = quot_nx[s];
            assign meta_b[s+1]  = meta_b[s];

            if (s < DIGIT_STEPS - 1) begin : g_mult_pass
                assign mult_b[s+1] = mult_b[s];
            end
        end
    end

    assign out_valid = valid_b[DIGIT_STEPS];
    assign quotient  = quot_b[DIGIT_STEPS];
    // final remainder sits in the upper word
    assign remainder = rem_b[DIGIT_STEPS][2*LEN_WORD-1:LEN_WORD];
    assign meta_out  = meta_b[DIGIT_STEPS];

endmodule

// File: hdl/div_operand_prep.sv
`timescale 1ns/10ps

module div_operand_prep (
    input  div_pkg::div_req_t  req,
    output core_pkg::word_t    dividend_abs,
    output core_pkg::word_t    divisor_abs,
    output div_pkg::div_meta_t meta
);
    import core_pkg::*;
    import div_pkg::*;

    logic is_signed;
    logic dividend_neg;
    logic divisor_neg;
    logic div_by_zero;

    assign is_signed = (req.op == DIV) || (req.op == REM);

    // sign bits only count for the signed ops
    assign dividend_neg = is_signed && req.dividend[LEN_WORD-1];
    assign divisor_neg  = is_signed && req.divisor[LEN_WORD-1];

    assign div_by_zero = (req.divisor == '0);

    // most negative value maps onto itself, read as unsigned 2^31
    assign dividend_abs = dividend_neg ? -req.dividend : req.dividend;
    assign divisor_abs  = divisor_neg  ? -req.divisor  : req.divisor;

    always_comb begin
        meta.tag         = req.tag;
        meta.want_rem    = (req.op == REM) || (req.op == REMU);
        // zero divisor keeps the all ones quotient unsigned
        meta.neg_quot    = (dividend_neg ^ divisor_neg) && !div_by_zero;
        // remainder follows the dividend sign
        meta.neg_rem     = dividend_neg;
        meta.div_by_zero = div_by_zero;
        meta.dividend    = req.dividend;
    end

endmodule

// File: hdl/div_result_fix.sv
`timescale 1ns/10ps

module div_result_fix (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 in_valid,
    input  core_pkg::word_t      quotient,
    input  core_pkg::word_t      remainder,
    input  div_pkg::div_meta_t   meta,
    output logic                 done,
    output div_pkg::div_result_t result
);
    import core_pkg::*;

    word_t quot_signed;
    word_t rem_signed;
    word_t value;

    assign quot_signed = meta.neg_quot ? -quotient  : quotient;
    assign rem_signed  = meta.neg_rem  ? -remainder : remainder;

    // divide by zero: all ones quotient, remainder is the dividend as given
    always_comb begin
        if (meta.want_rem) begin
            value = meta.div_by_zero ? meta.dividend : rem_signed;
        end else begin
            value = meta.div_by_zero ? '1 : quot_signed;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done <= 1'b0;
        end else begin
            done <= in_valid;
        end
    end

    // holds the last result between operations
    always_ff @(posedge clk) begin
        if (in_valid) begin
            result.value <= value;
            result.tag   <= meta.tag;
        end
    end

endmodule

// File: hdl/div_unit.sv
`timescale 1ns/10ps

module div_unit (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 order,
    input  div_pkg::div_req_t    req,
    output logic                 done,
    output div_pkg::div_result_t result
);
    import core_pkg::*;
    import div_pkg::*;

    // unsigned operands and meta into the core
    word_t     dividend_abs;
    word_t     divisor_abs;
    div_meta_t meta_in;

    // aligned core outputs
    logic      core_valid;
    word_t     core_quot;
    word_t     core_rem;
    div_meta_t meta_out;

    div_operand_prep u_prep (
        .req          (req),
        .dividend_abs (dividend_abs),
        .divisor_abs  (divisor_abs),
        .meta         (meta_in)
    );

    // every order is taken, the strobe is the valid
    divu_pipeline u_core (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (order),
        .dividend  (dividend_abs),
        .divisor   (divisor_abs),
        .meta_in   (meta_in),
        .out_valid (core_valid),
        .quotient  (core_quot),
        .remainder (core_rem),
        .meta_out  (meta_out)
    );

    div_result_fix u_fix (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (core_valid),
        .quotient  (core_quot),
        .remainder (core_rem),
        .meta      (meta_out),
        .done      (done),
        .result    (result)
    );

endmodule

// File: verification/div_unit_tb.sv
`timescale 1ns/10ps

module div_unit_tb;
    import core_pkg::*;
    import div_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 4;
    localparam int LATENCY      = 3;

    // operation counts per test group
    localparam int N_UNSIGNED       = 40;
    localparam int N_SMALL_DIVIDEND = 4;
    localparam int N_PER_SIGN       = 8;
    localparam int N_ZERO           = 8;
    localparam int N_OVERFLOW       = 4;
    localparam int N_BURST          = 24;
    localparam int NUM_OPS = N_UNSIGNED + N_SMALL_DIVIDEND + 4 * N_PER_SIGN
                           + N_ZERO + N_OVERFLOW + N_BURST;
    localparam int WATCHDOG_NS = (NUM_OPS + 20) * CLK_PERIOD;

    // one outstanding result and the cycle it must show up in
    typedef struct packed {
        word_t       value;
        preg_addr_t  tag;
        logic [31:0] due;
    } expect_t;

    logic        clk;
    logic        arst_n;
    logic        order;
    div_req_t    req;
    logic        done;
    div_result_t result;

    logic [31:0] lfsr_state;
    logic [31:0] cycle_cnt = '0;
    expect_t     exp_q [$];

    int value_errs    = 0;
    int tag_errs      = 0;
    int timing_errs   = 0;
    int protocol_errs = 0;

    div_unit dut (
        .clk    (clk),
        .arst_n (arst_n),
        .order  (order),
        .req    (req),
        .done   (done),
        .result (result)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit, bits gathered msb first
    function automatic word_t take_bits(int n);
        word_t bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits = {bits[LEN_WORD-2:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    function automatic div_op_t random_op();
        logic [1:0] code;
        code = 2'(take_bits(2));
        return div_op_t'(code);
    endfunction

    // RISC-V M extension divide and remainder semantics
    function automatic word_t ref_result(div_op_t op, word_t a, word_t b);
        logic want_rem;
        logic is_unsigned;
        want_rem    = op[1];
        is_unsigned = op[0];
        if (b == '0) begin
            return want_rem ? a : '1;
        end
        if (is_unsigned) begin
            return want_rem ? a % b : a / b;
        end
        if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            return want_rem ? '0 : a;
        end
        if (want_rem) begin
            return word_t'($signed(a) % $signed(b));
        end
        return word_t'($signed(a) / $signed(b));
    endfunction

    // drives one order on the next falling edge and books its result
    task automatic issue(div_op_t op, word_t a, word_t b);
        expect_t entry;
        @(negedge clk);
        order        = 1'b1;
        req.op       = op;
        req.dividend = a;
        req.divisor  = b;
        req.tag      = preg_addr_t'(take_bits(LEN_PREG_ADDR));
        entry.value  = ref_result(op, a, b);
        entry.tag    = req.tag;
        entry.due    = cycle_cnt + LATENCY;
        exp_q.push_back(entry);
    endtask

    // scoreboard
    always @(negedge clk) begin
        expect_t head;
        if (!arst_n) begin
            assert (done == 1'b0) else begin
                $display("done went high at %0d ns while reset was asserted", $time);
                protocol_errs++;
            end
        end else if (done) begin
            assert (exp_q.size() != 0) else begin
                $display("done went high at %0d ns with no order waiting for it", $time);
                protocol_errs++;
            end
            if (exp_q.size() != 0) begin
                head = exp_q.pop_front();
                assert (cycle_cnt == head.due) else begin
                    $display("Fail at %0d ns: done cycle got %0d expected %0d",
                             $time, cycle_cnt, head.due);
                    timing_errs++;
                end
                assert (result.value == head.value) else begin
                    $display("Fail at %0d ns: result.value got %h expected %h",
                             $time, result.value, head.value);
                    value_errs++;
                end
                assert (result.tag == head.tag) else begin
                    $display("Fail at %0d ns: result.tag got %0d expected %0d",
                             $time, result.tag, head.tag);
                    tag_errs++;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns with %0d results still outstanding",
                 WATCHDOG_NS, exp_q.size());
        $display("Simulation failed");
        $finish;
    end

    initial begin
        word_t a;
        word_t b;
        int    shift;
        int    missing;
        int    total;
        clk        = 1'b0;
        arst_n     = 1'b0;
        order      = 1'b0;
        req        = '0;
        lfsr_state = 32'h5e6f_cae4;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        // idle cycles, nothing may come out
        repeat (2) @(negedge clk);

        // unsigned, divisor scaled down so quotients span all widths
        for (int i = 0; i < N_UNSIGNED; i++) begin
            a     = take_bits(32);
            shift = int'(take_bits(5));
            b     = take_bits(32) >> shift;
            issue(i[0] ? REMU : DIVU, a, b);
        end

        // divisor above dividend
        for (int i = 0; i < N_SMALL_DIVIDEND; i++) begin
            a = take_bits(24);
            b = take_bits(32) | 32'h0100_0000;
            issue(i[0] ? REMU : DIVU, a, b);
        end

        // signed, one group per sign combination
        for (int sc = 0; sc < 4; sc++) begin
            for (int i = 0; i < N_PER_SIGN; i++) begin
                a     = take_bits(31);
                shift = int'(take_bits(4));
                b     = take_bits(31) >> shift;
                if (sc[0]) begin
                    a = -a;
                end
                if (sc[1]) begin
                    b = -b;
                end
                issue(take_bits(1) != 0 ? REM : DIV, a, b);
            end
        end

        // zero divisor in all four ops
        for (int i = 0; i < N_ZERO; i++) begin
            a = (i < 4) ? take_bits(32) : 32'h8000_0000 | take_bits(31);
            issue(div_op_t'(2'(i)), a, '0);
        end

        // most negative value over minus one
        issue(DIV, 32'h8000_0000, 32'hffff_ffff);
        issue(REM, 32'h8000_0000, 32'hffff_ffff);
        issue(DIVU, 32'h8000_0000, 32'hffff_ffff);
        issue(REMU, 32'h8000_0000, 32'hffff_ffff);

        // mixed burst
        for (int i = 0; i < N_BURST; i++) begin
            a     = take_bits(32);
            shift = int'(take_bits(5));
            b     = take_bits(32) >> shift;
            issue(random_op(), a, b);
        end

        @(negedge clk);
        order = 1'b0;

        for (int i = 0; i < LATENCY + 2 && exp_q.size() != 0; i++) begin
            @(negedge clk);
        end
        // a few quiet cycles to catch stray results
        repeat (3) @(negedge clk);

        missing = exp_q.size();
        assert (missing == 0) else begin
            $display("%0d results never arrived after their orders", missing);
        end

        total = value_errs + tag_errs + timing_errs + protocol_errs + missing;
        $display("errors: value %0d, tag %0d, timing %0d, protocol %0d, missing %0d",
                 value_errs, tag_errs, timing_errs, protocol_errs, missing);
        if (total == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
hdl/core_pkg.sv
hdl/div_pkg.sv
hdl/div_digit_step.sv
hdl/divu_pipeline.sv
hdl/div_operand_prep.sv
hdl/div_result_fix.sv
hdl/div_unit.sv
verification/div_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the divide unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f \
    --top-module div_unit_tb -o sim_div_unit \
    && ./obj_dir/sim_div_unit | tee /dev/stderr | grep -qx "Simulation passed" \
    && exit 0 \
    || exit 1
